//--- hw/twdl_num_pkg.sv
package twdl_num_pkg;

	// sample format Q1.17
	localparam int D_W = 18;
	// twiddle format Q2.14
	localparam int TW_W = 16;
	localparam int TW_FRAC = 14;
	localparam int TW_ONE = 16384;
	// sample times twiddle, and the complex sum of two of them
	localparam int PROD_W = D_W + TW_W;
	localparam int SUM_W = PROD_W + 1;
	// twiddle times twiddle, complex sum
	localparam int TWP_W = 2 * TW_W + 1;

	// phase is a fraction of one turn
	localparam int PHASE_W = 16;
	localparam int NUM_W = 12;
	// round(2^24 / N)
	localparam int RECIP_W = 24;
	localparam int FACTOR_W = 3;
	localparam int LANES = 5;

	// cordic datapath, guard bits below the twiddle lsb
	localparam int CORDIC_ITER = 16;
	localparam int XY_GRD = 2;
	localparam int XY_W = TW_W + XY_GRD + 2;
	localparam int Z_GRD = 4;
	localparam int Z_W = PHASE_W + Z_GRD + 1;
	// (TW_ONE << XY_GRD) / 1.64676, undoes the cordic gain
	localparam int CORDIC_X0 = 39797;
	// atan(2^-i) in units of 2^-20 turn
	localparam logic signed [Z_W-1:0] CORDIC_ATAN [CORDIC_ITER] = '{
		131072, 77376, 40883, 20753, 10417, 5213, 2607, 1304,
		652, 326, 163, 81, 41, 20, 10, 5
	};

	// latencies in cycles
	localparam int CORDIC_LAT = CORDIC_ITER + 1;
	localparam int POW_LAT = 4;
	localparam int ROT_DLY = CORDIC_LAT + POW_LAT;
	localparam int STAGE_LAT = ROT_DLY + 3;

	typedef struct packed {
		logic signed [D_W-1:0] re;
		logic signed [D_W-1:0] im;
	} cplx_t;

	typedef struct packed {
		logic signed [TW_W-1:0] re;
		logic signed [TW_W-1:0] im;
	} tw_t;

	// unrounded twiddle product, Q4.28
	typedef struct packed {
		logic signed [TWP_W-1:0] re;
		logic signed [TWP_W-1:0] im;
	} twp_t;

	typedef cplx_t [LANES-1:0] vec_t;
	// index 0 holds W^1, index 3 holds W^4
	typedef tw_t [LANES-2:0] tw_vec_t;

	localparam tw_t TW_UNIT = '{re: TW_W'(TW_ONE), im: '0};

endpackage

//--- hw/twdl_regs_pkg.sv
package twdl_regs_pkg;

	localparam int AXIL_AW = 8;
	localparam int AXIL_DW = 32;
	localparam int CNT_W = 16;

	// register map
	localparam logic [AXIL_AW-1:0] ADDR_CTRL = 8'h00;
	localparam logic [AXIL_AW-1:0] ADDR_RECIP = 8'h04;
	localparam logic [AXIL_AW-1:0] ADDR_STATUS = 8'h08;
	// ctrl word, factor sits in the low bits
	localparam int CTRL_BYPASS_BIT = 4;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic [AXIL_AW-1:0] awaddr;
		logic awvalid;
		logic [AXIL_DW-1:0] wdata;
		logic [AXIL_DW/8-1:0] wstrb;
		logic wvalid;
		logic bready;
		logic [AXIL_AW-1:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [AXIL_DW-1:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic [twdl_num_pkg::FACTOR_W-1:0] factor;
		logic bypass;
		logic [twdl_num_pkg::RECIP_W-1:0] recip;
	} twdl_cfg_t;

endpackage

//--- hw/twdl_axil_regs.sv
`timescale 1ns/100ps

module twdl_axil_regs
	import twdl_num_pkg::*;
	import twdl_regs_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input  logic      out_valid,
	output twdl_cfg_t cfg
);

	logic wr_rdy_q;
	logic bvalid_q;
	logic [1:0] bresp_q;
	logic ar_rdy_q;
	logic rvalid_q;
	logic [1:0] rresp_q;
	logic [AXIL_DW-1:0] rdata_q;
	twdl_cfg_t cfg_q;
	logic [CNT_W-1:0] cnt_q;
	logic wr_hs;
	logic rd_hs;
	logic wr_hit;
	logic rd_hit;
	logic [AXIL_DW-1:0] rd_word;

	// aw and w accepted together, ready only pulses for one cycle
	assign wr_hs = wr_rdy_q & axil_req.awvalid & axil_req.wvalid;
	assign rd_hs = ar_rdy_q & axil_req.arvalid;
	assign wr_hit = axil_req.awaddr inside {ADDR_CTRL, ADDR_RECIP, ADDR_STATUS};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_rdy_q <= 1'b0;
			bvalid_q <= 1'b0;
			bresp_q <= RESP_OKAY;
			cfg_q <= '0;
		end else begin
			// no new write while a response is still out
			wr_rdy_q <= axil_req.awvalid && axil_req.wvalid && !bvalid_q && !wr_rdy_q;
			if (wr_hs) begin
				bvalid_q <= 1'b1;
				bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
				// factor and bypass share byte 0
				if (axil_req.awaddr == ADDR_CTRL && axil_req.wstrb[0]) begin
					cfg_q.factor <= axil_req.wdata[FACTOR_W-1:0];
					cfg_q.bypass <= axil_req.wdata[CTRL_BYPASS_BIT];
				end
				if (axil_req.awaddr == ADDR_RECIP) begin
					for (int b = 0; b < RECIP_W / 8; b++) begin
						if (axil_req.wstrb[b]) begin
							cfg_q.recip[8*b +: 8] <= axil_req.wdata[8*b +: 8];
						end
					end
				end
			end else if (bvalid_q && axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
		end
	end

	// output vector count, wraps, any status write clears
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (wr_hs && axil_req.awaddr == ADDR_STATUS) begin
			cnt_q <= '0;
		end else if (out_valid) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// read mux
	always_comb begin
		rd_word = '0;
		rd_hit = 1'b1;
		case (axil_req.araddr)
			ADDR_CTRL: begin
				rd_word[FACTOR_W-1:0] = cfg_q.factor;
				rd_word[CTRL_BYPASS_BIT] = cfg_q.bypass;
			end
			ADDR_RECIP: rd_word[RECIP_W-1:0] = cfg_q.recip;
			ADDR_STATUS: rd_word[CNT_W-1:0] = cnt_q;
			default: rd_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ar_rdy_q <= 1'b0;
			rvalid_q <= 1'b0;
			rresp_q <= RESP_OKAY;
		end else begin
			ar_rdy_q <= axil_req.arvalid && !rvalid_q && !ar_rdy_q;
			if (rd_hs) begin
				rvalid_q <= 1'b1;
				rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			end else if (rvalid_q && axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// read data held until rready
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata_q <= rd_word;
		end
	end

	always_comb begin
		axil_rsp.awready = wr_rdy_q;
		axil_rsp.wready = wr_rdy_q;
		axil_rsp.bresp = bresp_q;
		axil_rsp.bvalid = bvalid_q;
		axil_rsp.arready = ar_rdy_q;
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = rresp_q;
		axil_rsp.rvalid = rvalid_q;
	end

	assign cfg = cfg_q;

endmodule

//--- hw/twdl_cordic.sv
`timescale 1ns/100ps

module twdl_cordic
	import twdl_num_pkg::*;
(
	input  logic               clk,
	input  logic [NUM_W-1:0]   num,
	input  logic [RECIP_W-1:0] recip,
	output tw_t                w
);

	logic [RECIP_W-1:0] frac;
	logic [PHASE_W-1:0] phase_q;
	logic [1:0] quad;
	logic signed [PHASE_W-1:0] resid;
	logic signed [XY_W-1:0] x_in [CORDIC_ITER];
	logic signed [XY_W-1:0] y_in [CORDIC_ITER];
	logic signed [Z_W-1:0] z_in [CORDIC_ITER];
	logic signed [XY_W-1:0] x_q [CORDIC_ITER];
	logic signed [XY_W-1:0] y_q [CORDIC_ITER];
	// last iteration needs no angle out
	logic signed [Z_W-1:0] z_q [CORDIC_ITER-1];
	logic signed [XY_W-1:0] x_rnd;
	logic signed [XY_W-1:0] y_rnd;

	// num/N in turns, keeping 24 bits wraps whole turns away
	assign frac = RECIP_W'(num) * recip;

	// top fraction bits, rounded
	always_ff @(posedge clk) begin
		phase_q <= frac[RECIP_W-1 -: PHASE_W] + PHASE_W'(frac[RECIP_W-PHASE_W-1]);
	end

	// nearest quarter turn, residual stays within +-45 deg
	assign quad = phase_q[PHASE_W-1 -: 2] + 2'(phase_q[PHASE_W-3]);
	assign resid = phase_q - (PHASE_W'(quad) << (PHASE_W - 2));

	always_comb begin
		// start vector pre-rotated by -quad * 90 deg
		case (quad)
			2'd0: begin
				x_in[0] = XY_W'(CORDIC_X0);
				y_in[0] = '0;
			end
			2'd1: begin
				x_in[0] = '0;
				y_in[0] = -XY_W'(CORDIC_X0);
			end
			2'd2: begin
				x_in[0] = -XY_W'(CORDIC_X0);
				y_in[0] = '0;
			end
			default: begin
				x_in[0] = '0;
				y_in[0] = XY_W'(CORDIC_X0);
			end
		endcase
		// negative angle gives exp(-j theta)
		z_in[0] = -(Z_W'(resid) <<< Z_GRD);
		for (int i = 1; i < CORDIC_ITER; i++) begin
			x_in[i] = x_q[i-1];
			y_in[i] = y_q[i-1];
			z_in[i] = z_q[i-1];
		end
	end

	// one shift-add micro-rotation per stage
	always_ff @(posedge clk) begin
		for (int i = 0; i < CORDIC_ITER; i++) begin
			if (!z_in[i][Z_W-1]) begin
				x_q[i] <= x_in[i] - (y_in[i] >>> i);
				y_q[i] <= y_in[i] + (x_in[i] >>> i);
			end else begin
				x_q[i] <= x_in[i] + (y_in[i] >>> i);
				y_q[i] <= y_in[i] - (x_in[i] >>> i);
			end
		end
		for (int i = 0; i < CORDIC_ITER - 1; i++) begin
			if (!z_in[i][Z_W-1]) begin
				z_q[i] <= z_in[i] - CORDIC_ATAN[i];
			end else begin
				z_q[i] <= z_in[i] + CORDIC_ATAN[i];
			end
		end
	end

	// drop guard bits with rounding
	assign x_rnd = x_q[CORDIC_ITER-1] + XY_W'(1 << (XY_GRD - 1));
	assign y_rnd = y_q[CORDIC_ITER-1] + XY_W'(1 << (XY_GRD - 1));
	assign w.re = x_rnd[XY_GRD +: TW_W];
	assign w.im = y_rnd[XY_GRD +: TW_W];

endmodule

//--- hw/twdl_powers.sv
`timescale 1ns/100ps

module twdl_powers
	import twdl_num_pkg::*;
(
	input  logic                clk,
	input  logic [FACTOR_W-1:0] factor,
	input  tw_t                 w,
	output tw_vec_t             tw
);

	tw_t w1_q;
	tw_t w1_d2;
	tw_t w1_d3;
	tw_t w1_d4;
	twp_t p2_q;
	tw_t w2;
	tw_t w2_q;
	tw_t w2_d4;
	twp_t p3_q;
	twp_t p4_q;

	// full complex product, Q2.14 times Q2.14
	function automatic twp_t cmul(input tw_t a, input tw_t b);
		cmul.re = TWP_W'(a.re * b.re) - TWP_W'(a.im * b.im);
		cmul.im = TWP_W'(a.re * b.im) + TWP_W'(a.im * b.re);
	endfunction

	// back to Q2.14, round half up
	function automatic tw_t tw_round(input twp_t p);
		logic signed [TWP_W-1:0] r;
		logic signed [TWP_W-1:0] i;
		r = p.re + TWP_W'(1 << (TW_FRAC - 1));
		i = p.im + TWP_W'(1 << (TW_FRAC - 1));
		tw_round.re = r[TW_FRAC +: TW_W];
		tw_round.im = i[TW_FRAC +: TW_W];
	endfunction

	always_ff @(posedge clk) begin
		// stage 1
		w1_q <= w;
		// stage 2 W squared
		p2_q <= cmul(w1_q, w1_q);
		w1_d2 <= w1_q;
		// stage 3 W^2 settled
		w2_q <= w2;
		w1_d3 <= w1_d2;
		// stage 4 W^3 and W^4 from the same W^2
		p3_q <= cmul(w1_d3, w2_q);
		p4_q <= cmul(w2_q, w2_q);
		w1_d4 <= w1_d3;
		w2_d4 <= w2_q;
	end

	// radix 2 butterflies want W^2 of exactly one
	assign w2 = (factor == FACTOR_W'(2)) ? TW_UNIT : tw_round(p2_q);

	assign tw[0] = w1_d4;
	assign tw[1] = w2_d4;
	// W^2 of one makes W^3 round back to W exactly
	assign tw[2] = tw_round(p3_q);
	assign tw[3] = tw_round(p4_q);

endmodule

//--- hw/twdl_rotate.sv
`timescale 1ns/100ps

module twdl_rotate
	import twdl_num_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  vec_t                in_vec,
	input  tw_vec_t             tw,
	input  logic [FACTOR_W-1:0] factor,
	input  logic                bypass,
	output logic                out_valid,
	output vec_t                out_vec
);

	logic [STAGE_LAT-1:0] v_q;
	// lines the data up with the twiddles
	vec_t d_q [ROT_DLY];
	vec_t dp_q;
	logic signed [PROD_W-1:0] p_rr_q [1:LANES-1];
	logic signed [PROD_W-1:0] p_ii_q [1:LANES-1];
	logic signed [PROD_W-1:0] p_ri_q [1:LANES-1];
	logic signed [PROD_W-1:0] p_ir_q [1:LANES-1];
	logic signed [SUM_W-1:0] s_re_q [LANES];
	logic signed [SUM_W-1:0] s_im_q [LANES];

	// sample placed at the product's scale, so rounding is exact
	function automatic logic signed [SUM_W-1:0] align(input logic signed [D_W-1:0] v);
		align = SUM_W'(v) <<< TW_FRAC;
	endfunction

	// keep 31:14, add bit 13
	function automatic logic signed [D_W-1:0] round_q(input logic signed [SUM_W-1:0] s);
		round_q = s[TW_FRAC +: D_W] + D_W'(s[TW_FRAC-1]);
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v_q <= '0;
		end else begin
			v_q <= {v_q[STAGE_LAT-2:0], in_valid};
		end
	end

	assign out_valid = v_q[STAGE_LAT-1];

	always_ff @(posedge clk) begin
		d_q[0] <= in_vec;
		for (int i = 1; i < ROT_DLY; i++) begin
			d_q[i] <= d_q[i-1];
		end
	end

	// stage 22 partial products, lane k takes W^k
	always_ff @(posedge clk) begin
		dp_q <= d_q[ROT_DLY-1];
		for (int k = 1; k < LANES; k++) begin
			p_rr_q[k] <= PROD_W'(d_q[ROT_DLY-1][k].re * tw[k-1].re);
			p_ii_q[k] <= PROD_W'(d_q[ROT_DLY-1][k].im * tw[k-1].im);
			p_ri_q[k] <= PROD_W'(d_q[ROT_DLY-1][k].re * tw[k-1].im);
			p_ir_q[k] <= PROD_W'(d_q[ROT_DLY-1][k].im * tw[k-1].re);
		end
	end

	// stage 23 complex sum
	always_ff @(posedge clk) begin
		// lane 0 never rotates
		s_re_q[0] <= align(dp_q[0].re);
		s_im_q[0] <= align(dp_q[0].im);
		for (int k = 1; k < LANES; k++) begin
			if (bypass) begin
				s_re_q[k] <= align(dp_q[k].re);
				s_im_q[k] <= align(dp_q[k].im);
			end else begin
				s_re_q[k] <= SUM_W'(p_rr_q[k]) - SUM_W'(p_ii_q[k]);
				s_im_q[k] <= SUM_W'(p_ri_q[k]) + SUM_W'(p_ir_q[k]);
			end
		end
	end

	// stage 24 rounded output
	// lanes past the radix and idle cycles read zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_vec <= '0;
		end else begin
			for (int k = 0; k < LANES; k++) begin
				if (v_q[STAGE_LAT-2] && k < int'(factor)) begin
					out_vec[k].re <= round_q(s_re_q[k]);
					out_vec[k].im <= round_q(s_im_q[k]);
				end else begin
					out_vec[k] <= '0;
				end
			end
		end
	end

endmodule

//--- hw/twdl_stage.sv
`timescale 1ns/100ps

module twdl_stage
	import twdl_num_pkg::*;
	import twdl_regs_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  axil_req_t        axil_req,
	output axil_rsp_t        axil_rsp,
	input  logic             in_valid,
	input  logic [NUM_W-1:0] in_num,
	input  vec_t             in_vec,
	output logic             out_valid,
	output vec_t             out_vec
);

	twdl_cfg_t cfg;
	// base twiddle from the cordic
	tw_t w;
	// W^1 to W^4
	tw_vec_t tw;

	twdl_axil_regs u_twdl_axil_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.out_valid (out_valid),
		.cfg       (cfg)
	);

	twdl_cordic u_twdl_cordic (
		.clk   (clk),
		.num   (in_num),
		.recip (cfg.recip),
		.w     (w)
	);

	twdl_powers u_twdl_powers (
		.clk    (clk),
		.factor (cfg.factor),
		.w      (w),
		.tw     (tw)
	);

	twdl_rotate u_twdl_rotate (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_vec    (in_vec),
		.tw        (tw),
		.factor    (cfg.factor),
		.bypass    (cfg.bypass),
		.out_valid (out_valid),
		.out_vec   (out_vec)
	);

endmodule

//--- dv/twdl_sva.sv
`timescale 1ns/100ps

module twdl_sva
	import twdl_num_pkg::*;
	import twdl_regs_pkg::*;
(
	input logic      clk,
	input logic      rst_n,
	input axil_req_t axil_req,
	input axil_rsp_t axil_rsp,
	input logic      out_valid,
	input vec_t      out_vec
);

	// failures seen so far, read by the testbench top
	int fail_count = 0;

	// idle cycles carry no data
	a_idle_lanes_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_vec == '0)
	else begin
		$error("output lanes not zero while out_valid is low");
		fail_count++;
	end

	// covers reset and the first cycle after release
	a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
	else begin
		$error("out_valid high during or right after reset");
		fail_count++;
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
	else begin
		$error("bvalid dropped before bready");
		fail_count++;
	end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
	else begin
		$error("rvalid dropped before rready");
		fail_count++;
	end

endmodule

//--- dv/twdl_checker.sv
`timescale 1ns/100ps

module twdl_checker
	import twdl_num_pkg::*;
	import twdl_regs_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [NUM_W-1:0] in_num,
	input  vec_t             in_vec,
	input  twdl_cfg_t        cfg,
	input  logic             out_valid,
	input  vec_t             out_vec,
	output int               err_count,
	output int               in_count,
	output int               out_count
);

	localparam real TWO_PI = 6.283185307179586;
	// allowed error per component in twiddle mode, in output lsb
	localparam int TOL = 8;

	// inputs still in flight, oldest first
	vec_t q_vec [$];
	logic [NUM_W-1:0] q_num [$];
	twdl_cfg_t q_cfg [$];
	longint q_cyc [$];
	longint cyc;

	function automatic int round_real(input real x);
		if (x >= 0.0) begin
			round_real = $rtoi(x + 0.5);
		end else begin
			round_real = -$rtoi(0.5 - x);
		end
	endfunction

	// num/N in turns, whole turns wrap away
	function automatic real phase_of(input logic [NUM_W-1:0] num, input logic [RECIP_W-1:0] recip);
		longint frac;
		frac = (longint'(num) * longint'(recip)) % (longint'(1) << RECIP_W);
		phase_of = TWO_PI * real'(frac) / real'(longint'(1) << RECIP_W);
	endfunction

	task automatic compare_part(input int lane, input string part, input int got, input int exp,
			input int tol);
		int diff;
		diff = got - exp;
		if (diff < 0) begin
			diff = -diff;
		end
		if (diff > tol) begin
			$display("CHECK FAILED @%0t: output %0d lane %0d %s got %0d expected %0d",
				$time, out_count, lane, part, got, exp);
			err_count++;
		end
	endtask

	task automatic check_vector(input vec_t din, input vec_t dout, input logic [NUM_W-1:0] num,
			input twdl_cfg_t c);
		real theta;
		real a;
		real b;
		int exp_re;
		int exp_im;
		int tol;
		theta = phase_of(num, c.recip);
		for (int k = 0; k < LANES; k++) begin
			a = real'(int'(din[k].re));
			b = real'(int'(din[k].im));
			if (k >= int'(c.factor)) begin
				// lane beyond the radix
				exp_re = 0;
				exp_im = 0;
				tol = 0;
			end else if (c.bypass || k == 0) begin
				exp_re = int'(din[k].re);
				exp_im = int'(din[k].im);
				tol = 0;
			end else begin
				// (a + jb) * exp(-j k theta)
				exp_re = round_real(a * $cos(k * theta) + b * $sin(k * theta));
				exp_im = round_real(b * $cos(k * theta) - a * $sin(k * theta));
				tol = TOL;
			end
			compare_part(k, "re", int'(dout[k].re), exp_re, tol);
			compare_part(k, "im", int'(dout[k].im), exp_im, tol);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			cyc = 0;
			err_count = 0;
			in_count = 0;
			out_count = 0;
			q_vec.delete();
			q_num.delete();
			q_cfg.delete();
			q_cyc.delete();
		end else begin
			cyc++;
			// each accepted input keeps the config it was sent under
			if (in_valid) begin
				q_vec.push_back(in_vec);
				q_num.push_back(in_num);
				q_cfg.push_back(cfg);
				q_cyc.push_back(cyc);
				in_count++;
			end
			if (out_valid) begin
				if (q_vec.size() == 0) begin
					$display("output vector at %0t arrived with no input outstanding", $time);
					err_count++;
				end else begin
					if (cyc - q_cyc[0] != longint'(STAGE_LAT)) begin
						$display("CHECK FAILED @%0t: output %0d latency %0d expected %0d",
							$time, out_count, cyc - q_cyc[0], STAGE_LAT);
						err_count++;
					end
					check_vector(q_vec[0], out_vec, q_num[0], q_cfg[0]);
					void'(q_vec.pop_front());
					void'(q_num.pop_front());
					void'(q_cfg.pop_front());
					void'(q_cyc.pop_front());
				end
				out_count++;
			end
		end
	end

endmodule

//--- dv/twdl_tb.sv
`timescale 1ns/100ps

module twdl_tb
	import twdl_num_pkg::*;
	import twdl_regs_pkg::*;
();

	localparam int CLK_HALF = 20;
	localparam int RST_CYC = 4;
	localparam int IN_DLY = 2;
	localparam int BURST_LEN = 60;
	localparam int DRAIN = 30;
	localparam int N_BURSTS = 14;
	// register traffic per burst, and for the register tests
	localparam int CFG_CYC = 16;
	localparam int REG_CYC = 120;
	localparam int TIMEOUT_CYC = 2 * (N_BURSTS * (BURST_LEN + DRAIN + CFG_CYC) + REG_CYC);
	// twiddle error grows with amplitude, so rotated bursts stay small
	localparam int TW_AMP = 4096;
	localparam int FULL_AMP = (1 << 17) - 64;
	localparam logic [AXIL_AW-1:0] ADDR_HOLE_W = 8'h10;
	localparam logic [AXIL_AW-1:0] ADDR_HOLE_R = 8'h0c;

	logic clk;
	logic rst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic in_valid;
	logic [NUM_W-1:0] in_num;
	vec_t in_vec;
	logic out_valid;
	vec_t out_vec;
	// register contents as software expects them
	twdl_cfg_t cfg_model;
	logic [AXIL_DW-1:0] ctrl_model;
	logic [AXIL_DW-1:0] recip_model;
	int status_base;
	int current_n;
	int tb_errors;
	int chk_errors;
	int chk_in;
	int chk_out;
	int sva_errors;

	twdl_stage u_twdl_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.in_valid  (in_valid),
		.in_num    (in_num),
		.in_vec    (in_vec),
		.out_valid (out_valid),
		.out_vec   (out_vec)
	);

	twdl_checker u_twdl_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_num    (in_num),
		.in_vec    (in_vec),
		.cfg       (cfg_model),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.err_count (chk_errors),
		.in_count  (chk_in),
		.out_count (chk_out)
	);

	bind twdl_stage twdl_sva u_twdl_sva (
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.out_valid (out_valid),
		.out_vec   (out_vec)
	);

	always #CLK_HALF clk = ~clk;

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYC);
		$display("Errors found");
		$finish;
	end

	function automatic int rand_comp(input int amp);
		rand_comp = int'($urandom % (2 * amp + 1)) - amp;
	endfunction

	function automatic logic is_mapped(input logic [AXIL_AW-1:0] addr);
		is_mapped = addr == ADDR_CTRL || addr == ADDR_RECIP || addr == ADDR_STATUS;
	endfunction

	// vectors fed in since the last status clear, each leaves once, 16 bit wrap
	function automatic logic [AXIL_DW-1:0] status_expect();
		status_expect = AXIL_DW'((chk_in - status_base) & 32'hffff);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED @%0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			tb_errors++;
		end
	endtask

	// called and returns at IN_DLY after a rising edge
	task automatic axil_write(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		axil_req.awaddr = addr;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		do begin
			@(posedge clk);
			#IN_DLY;
		end while (!(axil_rsp.awready && axil_rsp.wready));
		// handshake on this edge
		@(posedge clk);
		#IN_DLY;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		// response left waiting one cycle
		@(posedge clk);
		#IN_DLY;
		axil_req.bready = 1'b1;
		while (!axil_rsp.bvalid) begin
			@(posedge clk);
			#IN_DLY;
		end
		resp = axil_rsp.bresp;
		@(posedge clk);
		#IN_DLY;
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [AXIL_AW-1:0] addr, output logic [AXIL_DW-1:0] data,
			output logic [1:0] resp);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		do begin
			@(posedge clk);
			#IN_DLY;
		end while (!axil_rsp.arready);
		@(posedge clk);
		#IN_DLY;
		axil_req.arvalid = 1'b0;
		// read data left waiting one cycle
		@(posedge clk);
		#IN_DLY;
		axil_req.rready = 1'b1;
		while (!axil_rsp.rvalid) begin
			@(posedge clk);
			#IN_DLY;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		#IN_DLY;
		axil_req.rready = 1'b0;
	endtask

	// write and apply the byte strobes to the register model
	task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] data,
			input logic [3:0] strb);
		logic [1:0] resp;
		axil_write(addr, data, strb, resp);
		check_value($sformatf("bresp at 0x%02h", addr), 32'(resp),
			32'(is_mapped(addr) ? RESP_OKAY : RESP_SLVERR));
		if (addr == ADDR_CTRL && strb[0]) begin
			ctrl_model = data & 32'h0000_0017;
		end
		if (addr == ADDR_RECIP) begin
			for (int b = 0; b < 3; b++) begin
				if (strb[b]) begin
					recip_model[8*b +: 8] = data[8*b +: 8];
				end
			end
		end
		if (addr == ADDR_STATUS) begin
			status_base = chk_in;
		end
		cfg_model.factor = ctrl_model[FACTOR_W-1:0];
		cfg_model.bypass = ctrl_model[CTRL_BYPASS_BIT];
		cfg_model.recip = recip_model[RECIP_W-1:0];
	endtask

	task automatic check_reg(input logic [AXIL_AW-1:0] addr, input logic [AXIL_DW-1:0] exp);
		logic [AXIL_DW-1:0] data;
		logic [1:0] resp;
		axil_read(addr, data, resp);
		check_value($sformatf("rresp at 0x%02h", addr), 32'(resp),
			32'(is_mapped(addr) ? RESP_OKAY : RESP_SLVERR));
		if (is_mapped(addr)) begin
			check_value($sformatf("register 0x%02h", addr), data, exp);
		end
	endtask

	// recip = round(2^24 / n)
	task automatic set_config(input int f, input logic byp, input int n);
		write_reg(ADDR_RECIP, AXIL_DW'(((1 << 24) + n / 2) / n), 4'hf);
		write_reg(ADDR_CTRL, AXIL_DW'(f) | (AXIL_DW'(byp) << CTRL_BYPASS_BIT), 4'h1);
		current_n = n;
	endtask

	// random vectors, then a drain so the pipeline is empty again
	task automatic run_burst(input int amp, input logic all_valid);
		for (int i = 0; i < BURST_LEN; i++) begin
			in_valid = all_valid || (($urandom % 4) != 0);
			in_num = NUM_W'($urandom % current_n);
			for (int k = 0; k < LANES; k++) begin
				in_vec[k].re = D_W'(rand_comp(amp));
				in_vec[k].im = D_W'(rand_comp(amp));
			end
			@(posedge clk);
			#IN_DLY;
		end
		in_valid = 1'b0;
		repeat (DRAIN) @(posedge clk);
		#IN_DLY;
		check_value("output count", 32'(chk_out), 32'(chk_in));
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		axil_req = '0;
		in_valid = 1'b0;
		in_num = '0;
		in_vec = '0;
		cfg_model = '0;
		ctrl_model = '0;
		recip_model = '0;
		status_base = 0;
		current_n = 1;
		tb_errors = 0;
		void'($urandom(32'h8f93));
		repeat (RST_CYC) @(posedge clk);
		#IN_DLY;
		rst_n = 1'b1;
		@(posedge clk);
		#IN_DLY;

		// readback with byte strobes
		write_reg(ADDR_CTRL, 32'h0000_0013, 4'h1);
		check_reg(ADDR_CTRL, ctrl_model);
		write_reg(ADDR_CTRL, 32'h0000_0005, 4'h0);
		check_reg(ADDR_CTRL, ctrl_model);
		write_reg(ADDR_RECIP, 32'h00ab_cdef, 4'hf);
		check_reg(ADDR_RECIP, recip_model);
		write_reg(ADDR_RECIP, 32'hff12_3456, 4'h5);
		check_reg(ADDR_RECIP, recip_model);

		// every radix, three transform sizes each
		for (int f = 2; f <= 5; f++) begin
			for (int j = 0; j < 3; j++) begin
				set_config(f, 1'b0, (j == 0) ? 4 * f : (j == 1) ? 64 * f : 4000 + f);
				// first burst of a radix is back to back
				run_burst(TW_AMP, j == 0);
			end
		end
		set_config(3, 1'b1, 100);
		run_burst(FULL_AMP, 1'b0);
		set_config(5, 1'b1, 4095);
		run_burst(FULL_AMP, 1'b1);

		// holes in the map, status still holds the output count
		write_reg(ADDR_HOLE_W, 32'hffff_ffff, 4'hf);
		check_reg(ADDR_CTRL, ctrl_model);
		check_reg(ADDR_RECIP, recip_model);
		check_reg(ADDR_STATUS, status_expect());
		check_reg(ADDR_HOLE_R, '0);

		// any status write clears it
		write_reg(ADDR_STATUS, 32'h0000_1234, 4'hf);
		check_reg(ADDR_STATUS, 32'h0);

		sva_errors = u_twdl_stage.u_twdl_sva.fail_count;
		$display("summary: %0d testbench, %0d checker, %0d assertion errors, %0d in, %0d out",
			tb_errors, chk_errors, sva_errors, chk_in, chk_out);
		if (tb_errors + chk_errors + sva_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- twdl_stage.f
hw/twdl_num_pkg.sv
hw/twdl_regs_pkg.sv
hw/twdl_axil_regs.sv
hw/twdl_cordic.sv
hw/twdl_powers.sv
hw/twdl_rotate.sv
hw/twdl_stage.sv
dv/twdl_sva.sv
dv/twdl_checker.sv
dv/twdl_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= twdl_tb
FILELIST ?= twdl_stage.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
